// ==== design/bridge_pkg.sv ====
// shared widths, marker bytes and FIFO word layout for the packet-to-bus bridge
// imported by every RTL block and by the testbench
`default_nettype none

package bridge_pkg;

  localparam int FIFO_W  = 128;  // FIFO word
  localparam int BEAT_W  = 64;   // bus data beat
  localparam int ID_W    = 4;
  localparam int ADDR_W  = 32;
  localparam int LEN_W   = 4;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int LOCK_W  = 2;
  localparam int CACHE_W = 2;
  localparam int PROT_W  = 3;
  localparam int STRB_W  = 4;
  localparam int RESP_W  = 2;

  localparam int MARK_W    = 8;   // start and end marker bytes
  localparam int KIND_W    = 16;
  localparam int RSVD_W    = 48;
  localparam int RSP_FLD_W = 4;   // bresp slot in the response word

  localparam logic [MARK_W-1:0] SOP_BYTE = 8'hAA;
  localparam logic [MARK_W-1:0] EOP_BYTE = 8'h53;
  localparam logic [KIND_W-1:0] RD_KIND  = 16'h0113;  // anything else is a write

  // tags on the parser to generator link
  localparam int TAG_W = 2;
  localparam logic [TAG_W-1:0] TAG_HDR_RD = 2'd0;
  localparam logic [TAG_W-1:0] TAG_HDR_WR = 2'd1;
  localparam logic [TAG_W-1:0] TAG_DATA   = 2'd2;
  localparam logic [TAG_W-1:0] TAG_TRAIL  = 2'd3;

  // parser FSM states
  localparam int PS_W = 2;
  localparam logic [PS_W-1:0] PS_HDR = 2'd0;  // waiting for a header
  localparam logic [PS_W-1:0] PS_DHI = 2'd1;
  localparam logic [PS_W-1:0] PS_DLO = 2'd2;
  localparam logic [PS_W-1:0] PS_TRL = 2'd3;

  // a FIFO word seen as a request header or as two payload halves
  typedef union packed {
    struct packed {
      logic [MARK_W-1:0]  sop;
      logic [ID_W-1:0]    id;
      logic [ADDR_W-1:0]  addr;
      logic [LEN_W-1:0]   len;
      logic [SIZE_W-1:0]  size;
      logic [BURST_W-1:0] burst;
      logic [LOCK_W-1:0]  lock;
      logic [CACHE_W-1:0] cache;
      logic [PROT_W-1:0]  prot;
      logic [STRB_W-1:0]  strb;
      logic [KIND_W-1:0]  kind;
      logic [RSVD_W-1:0]  rsvd;
    } hdr;
    struct packed {
      logic [BEAT_W-1:0] hi;  // sent first
      logic [BEAT_W-1:0] lo;
    } half;
  } fifo_word_u;

endpackage

`default_nettype wire

// ==== design/pkt_if.sv ====
// parsed word link from the packet parser to the request generator
// one item per valid pulse and the generator always accepts
`timescale 1ns/1ns
`default_nettype none

interface pkt_if;
  import bridge_pkg::*;

  logic             valid;    // one-cycle pulse per item
  logic [TAG_W-1:0] tag;
  fifo_word_u       word;
  logic             lo_half;  // data or trailer sits in the low half
  logic             last;     // final payload beat of the packet

  modport parser (
    output valid,
    output tag,
    output word,
    output lo_half,
    output last
  );

  modport gen (
    input valid,
    input tag,
    input word,
    input lo_half,
    input last
  );

endinterface

`default_nettype wire

// ==== design/pkt_parser.sv ====
// input side of the bridge that pops the FWFT FIFO, finds headers and tags payload halves
// items leave on pkt one cycle after their half was presented
`timescale 1ns/1ns
`default_nettype none

module pkt_parser (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fifo_empty,
  input  bridge_pkg::fifo_word_u fifo_rdata,
  output logic                   read_enable,
  output logic                   sop_err,
  pkt_if.parser                  pkt
);
  import bridge_pkg::*;

  logic [PS_W-1:0]  state;
  logic [PS_W-1:0]  state_nxt;
  logic [LEN_W:0]   beat_cnt;  // payload beats still to tag
  logic [LEN_W:0]   beats;
  logic             trl_lo;    // trailer lands in the low half
  logic             is_sop;
  logic             is_rd;

  assign is_sop = (fifo_rdata.hdr.sop == SOP_BYTE);
  assign is_rd  = (fifo_rdata.hdr.kind == RD_KIND);
  assign beats  = {1'b0, fifo_rdata.hdr.len} + 1'b1;

  // pop decision and next state wait while the FIFO is empty
  always_comb
  begin
    read_enable = 1'b0;
    state_nxt   = state;
    case (state)
      PS_HDR:
      begin
        if (!fifo_empty)
        begin
          read_enable = 1'b1;  // header or junk word is popped either way
          if (is_sop && !is_rd)
          begin
            state_nxt = PS_DHI;
          end
        end
      end
      PS_DHI:
      begin
        if (!fifo_empty)
        begin
          // last beat in a hi half puts the trailer in the lo half
          state_nxt = (beat_cnt == 1) ? PS_TRL : PS_DLO;
        end
      end
      PS_DLO:
      begin
        if (!fifo_empty)
        begin
          read_enable = 1'b1;
          state_nxt   = (beat_cnt == 1) ? PS_TRL : PS_DHI;
        end
      end
      PS_TRL:
      begin
        if (!fifo_empty)
        begin
          read_enable = 1'b1;  // a hi-half trailer discards the lo half
          state_nxt   = PS_HDR;
        end
      end
      default:
      begin
        state_nxt = PS_HDR;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state       <= PS_HDR;
      beat_cnt    <= '0;
      trl_lo      <= 1'b0;
      sop_err     <= 1'b0;
      pkt.valid   <= 1'b0;
      pkt.tag     <= TAG_HDR_RD;
      pkt.lo_half <= 1'b0;
      pkt.last    <= 1'b0;
    end
    else
    begin
      state     <= state_nxt;
      sop_err   <= 1'b0;
      pkt.valid <= 1'b0;
      pkt.last  <= 1'b0;
      if (!fifo_empty)
      begin
        case (state)
          PS_HDR:
          begin
            if (is_sop)
            begin
              pkt.valid   <= 1'b1;
              pkt.tag     <= is_rd ? TAG_HDR_RD : TAG_HDR_WR;
              pkt.lo_half <= 1'b0;
              if (!is_rd)
              begin
                beat_cnt <= beats;
                trl_lo   <= beats[0];  // parity fixes the trailer position
              end
            end
            else
            begin
              sop_err <= 1'b1;  // non-header word is dropped
            end
          end
          PS_DHI, PS_DLO:
          begin
            pkt.valid   <= 1'b1;
            pkt.tag     <= TAG_DATA;
            pkt.lo_half <= (state == PS_DLO);
            pkt.last    <= (beat_cnt == 1);
            beat_cnt    <= beat_cnt - 1'b1;
          end
          default:
          begin
            pkt.valid   <= 1'b1;
            pkt.tag     <= TAG_TRAIL;
            pkt.lo_half <= trl_lo;
          end
        endcase
      end
    end
  end

  // word travels alongside the tag
  always_ff @(posedge clk)
  begin
    if (!fifo_empty)
    begin
      pkt.word <= fifo_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== design/req_gen.sv ====
// request generator that turns tagged words into read and write requests and write beats
// all outputs are registered one cycle behind the parser link
`timescale 1ns/1ns
`default_nettype none

module req_gen (
  input  logic                           clk,
  input  logic                           rst_n,
  pkt_if.gen                             pkt,
  output logic                           rd_req,
  output logic                           wr_req,
  output logic [bridge_pkg::ID_W-1:0]    ar_id,
  output logic [bridge_pkg::ID_W-1:0]    aw_id,
  output logic [bridge_pkg::ADDR_W-1:0]  ar_addr,
  output logic [bridge_pkg::ADDR_W-1:0]  aw_addr,
  output logic [bridge_pkg::LEN_W-1:0]   ar_len,
  output logic [bridge_pkg::LEN_W-1:0]   aw_len,
  output logic [bridge_pkg::SIZE_W-1:0]  ar_size,
  output logic [bridge_pkg::SIZE_W-1:0]  aw_size,
  output logic [bridge_pkg::BURST_W-1:0] ar_burst,
  output logic [bridge_pkg::BURST_W-1:0] aw_burst,
  output logic [bridge_pkg::LOCK_W-1:0]  ar_lock,
  output logic [bridge_pkg::LOCK_W-1:0]  aw_lock,
  output logic [bridge_pkg::CACHE_W-1:0] ar_cache,
  output logic [bridge_pkg::CACHE_W-1:0] aw_cache,
  output logic [bridge_pkg::PROT_W-1:0]  ar_prot,
  output logic [bridge_pkg::PROT_W-1:0]  aw_prot,
  output logic [bridge_pkg::STRB_W-1:0]  w_strb,
  output logic                           w_valid,
  output logic                           w_last,
  output logic [bridge_pkg::BEAT_W-1:0]  w_data,
  output logic                           eop_err
);
  import bridge_pkg::*;

  logic [BEAT_W-1:0] sel_half;  // the half this item refers to

  assign sel_half = pkt.lo_half ? pkt.word.half.lo : pkt.word.half.hi;

  // strobes and error
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_req  <= 1'b0;
      wr_req  <= 1'b0;
      w_valid <= 1'b0;
      w_last  <= 1'b0;
      eop_err <= 1'b0;
    end
    else
    begin
      rd_req  <= pkt.valid && (pkt.tag == TAG_HDR_RD);
      wr_req  <= pkt.valid && (pkt.tag == TAG_HDR_WR);
      w_valid <= pkt.valid && (pkt.tag == TAG_DATA);
      w_last  <= pkt.valid && (pkt.tag == TAG_DATA) && pkt.last;
      // trailer half has to open with the end marker
      eop_err <= pkt.valid && (pkt.tag == TAG_TRAIL) &&
                 (sel_half[BEAT_W-1 -: MARK_W] != EOP_BYTE);
    end
  end

  // request fields held until the next header of the same kind
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ar_id    <= '0;
      ar_addr  <= '0;
      ar_len   <= '0;
      ar_size  <= '0;
      ar_burst <= '0;
      ar_lock  <= '0;
      ar_cache <= '0;
      ar_prot  <= '0;
      aw_id    <= '0;
      aw_addr  <= '0;
      aw_len   <= '0;
      aw_size  <= '0;
      aw_burst <= '0;
      aw_lock  <= '0;
      aw_cache <= '0;
      aw_prot  <= '0;
      w_strb   <= '0;
      w_data   <= '0;
    end
    else if (pkt.valid)
    begin
      case (pkt.tag)
        TAG_HDR_RD:
        begin
          ar_id    <= pkt.word.hdr.id;
          ar_addr  <= pkt.word.hdr.addr;
          ar_len   <= pkt.word.hdr.len;
          ar_size  <= pkt.word.hdr.size;
          ar_burst <= pkt.word.hdr.burst;
          ar_lock  <= pkt.word.hdr.lock;
          ar_cache <= pkt.word.hdr.cache;
          ar_prot  <= pkt.word.hdr.prot;
        end
        TAG_HDR_WR:
        begin
          aw_id    <= pkt.word.hdr.id;
          aw_addr  <= pkt.word.hdr.addr;
          aw_len   <= pkt.word.hdr.len;
          aw_size  <= pkt.word.hdr.size;  // beat count ignores the size
          aw_burst <= pkt.word.hdr.burst;
          aw_lock  <= pkt.word.hdr.lock;
          aw_cache <= pkt.word.hdr.cache;
          aw_prot  <= pkt.word.hdr.prot;
          w_strb   <= pkt.word.hdr.strb;  // same strobe on every beat
        end
        TAG_DATA:
        begin
          w_data <= sel_half;
        end
        default:
        begin
          w_data <= w_data;  // trailer carries no beat
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/rsp_packer.sv ====
// output side that packs a write response into a 128-bit word for the response FIFO
// from the top down the word holds zeros, start marker, bid, padded bresp and end marker
`timescale 1ns/1ns
`default_nettype none

module rsp_packer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          wr_rsp_en,
  input  logic [bridge_pkg::ID_W-1:0]   bid,
  input  logic [bridge_pkg::RESP_W-1:0] bresp,
  output logic                          rsp_write,
  output logic [bridge_pkg::FIFO_W-1:0] rsp_data
);
  import bridge_pkg::*;

  logic [FIFO_W-1:0] rsp_word;

  assign rsp_word = {{(FIFO_W - 2*MARK_W - ID_W - RSP_FLD_W){1'b0}},
                     SOP_BYTE,
                     bid,
                     {(RSP_FLD_W - RESP_W){1'b0}}, bresp,
                     EOP_BYTE};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rsp_write <= 1'b0;
      rsp_data  <= '0;
    end
    else
    begin
      rsp_write <= wr_rsp_en;
      rsp_data  <= wr_rsp_en ? rsp_word : '0;  // zero between responses
    end
  end

endmodule

`default_nettype wire

// ==== design/axi_pkt_bridge.sv ====
// top of the packet-to-bus request bridge
// FIFO in, read and write requests plus write beats out, write responses packed back
`timescale 1ns/1ns
`default_nettype none

module axi_pkt_bridge (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           fifo_empty,
  input  logic [bridge_pkg::FIFO_W-1:0]  fifo_rdata,
  output logic                           read_enable,
  output logic                           sop_err,
  output logic                           rd_req,
  output logic                           wr_req,
  output logic [bridge_pkg::ID_W-1:0]    ar_id,
  output logic [bridge_pkg::ID_W-1:0]    aw_id,
  output logic [bridge_pkg::ADDR_W-1:0]  ar_addr,
  output logic [bridge_pkg::ADDR_W-1:0]  aw_addr,
  output logic [bridge_pkg::LEN_W-1:0]   ar_len,
  output logic [bridge_pkg::LEN_W-1:0]   aw_len,
  output logic [bridge_pkg::SIZE_W-1:0]  ar_size,
  output logic [bridge_pkg::SIZE_W-1:0]  aw_size,
  output logic [bridge_pkg::BURST_W-1:0] ar_burst,
  output logic [bridge_pkg::BURST_W-1:0] aw_burst,
  output logic [bridge_pkg::LOCK_W-1:0]  ar_lock,
  output logic [bridge_pkg::LOCK_W-1:0]  aw_lock,
  output logic [bridge_pkg::CACHE_W-1:0] ar_cache,
  output logic [bridge_pkg::CACHE_W-1:0] aw_cache,
  output logic [bridge_pkg::PROT_W-1:0]  ar_prot,
  output logic [bridge_pkg::PROT_W-1:0]  aw_prot,
  output logic [bridge_pkg::STRB_W-1:0]  w_strb,
  output logic                           w_valid,
  output logic                           w_last,
  output logic [bridge_pkg::BEAT_W-1:0]  w_data,
  output logic                           eop_err,
  input  logic                           wr_rsp_en,
  input  logic [bridge_pkg::ID_W-1:0]    bid,
  input  logic [bridge_pkg::RESP_W-1:0]  bresp,
  output logic                           rsp_write,
  output logic [bridge_pkg::FIFO_W-1:0]  rsp_data
);

  pkt_if pkt ();  // parser to generator

  pkt_parser i_parser (
    .clk         (clk),
    .rst_n       (rst_n),
    .fifo_empty  (fifo_empty),
    .fifo_rdata  (fifo_rdata),
    .read_enable (read_enable),
    .sop_err     (sop_err),
    .pkt         (pkt.parser)
  );

  req_gen i_req_gen (
    .clk      (clk),
    .rst_n    (rst_n),
    .pkt      (pkt.gen),
    .rd_req   (rd_req),
    .wr_req   (wr_req),
    .ar_id    (ar_id),
    .aw_id    (aw_id),
    .ar_addr  (ar_addr),
    .aw_addr  (aw_addr),
    .ar_len   (ar_len),
    .aw_len   (aw_len),
    .ar_size  (ar_size),
    .aw_size  (aw_size),
    .ar_burst (ar_burst),
    .aw_burst (aw_burst),
    .ar_lock  (ar_lock),
    .aw_lock  (aw_lock),
    .ar_cache (ar_cache),
    .aw_cache (aw_cache),
    .ar_prot  (ar_prot),
    .aw_prot  (aw_prot),
    .w_strb   (w_strb),
    .w_valid  (w_valid),
    .w_last   (w_last),
    .w_data   (w_data),
    .eop_err  (eop_err)
  );

  rsp_packer i_rsp_packer (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_rsp_en (wr_rsp_en),
    .bid       (bid),
    .bresp     (bresp),
    .rsp_write (rsp_write),
    .rsp_data  (rsp_data)
  );

endmodule

`default_nettype wire

// ==== verif/axi_pkt_bridge_assert.sv ====
// protocol rules on the top-level ports of the bridge
// bound into axi_pkt_bridge and counts failed rules in fail_cnt
`timescale 1ns/1ns
`default_nettype none

module axi_pkt_bridge_assert (
  input logic clk,
  input logic rst_n,
  input logic fifo_empty,
  input logic read_enable,
  input logic rd_req,
  input logic wr_req,
  input logic w_valid,
  input logic w_last,
  input logic wr_rsp_en,
  input logic rsp_write
);

  int fail_cnt = 0;  // failures so far

  a_pop_needs_data: assert property (@(posedge clk) disable iff (!rst_n)
    read_enable |-> !fifo_empty)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("read_enable while fifo_empty");
  end

  a_one_request: assert property (@(posedge clk) disable iff (!rst_n)
    !(rd_req && wr_req))
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("rd_req and wr_req together");
  end

  a_last_in_beat: assert property (@(posedge clk) disable iff (!rst_n)
    w_last |-> w_valid)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("w_last without w_valid");
  end

  // response write is exactly one cycle behind its enable
  a_rsp_follows: assert property (@(posedge clk) disable iff (!rst_n)
    wr_rsp_en |=> rsp_write)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("rsp_write missing after wr_rsp_en");
  end

  a_rsp_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !wr_rsp_en |=> !rsp_write)
  else
  begin
    fail_cnt = fail_cnt + 1;
    $error("rsp_write without wr_rsp_en");
  end

endmodule

bind axi_pkt_bridge axi_pkt_bridge_assert i_bridge_assert (
  .clk         (clk),
  .rst_n       (rst_n),
  .fifo_empty  (fifo_empty),
  .read_enable (read_enable),
  .rd_req      (rd_req),
  .wr_req      (wr_req),
  .w_valid     (w_valid),
  .w_last      (w_last),
  .wr_rsp_en   (wr_rsp_en),
  .rsp_write   (rsp_write)
);

`default_nettype wire

// ==== verif/axi_pkt_bridge_tb.sv ====
// testbench for the packet-to-bus bridge
// table entries go through a FIFO model and every output pulse is matched
// against queues of expected values built from the table
`timescale 1ns/1ns
`default_nettype none

module axi_pkt_bridge_tb;
  import bridge_pkg::*;

  localparam logic [2:0] K_RD   = 3'd0;
  localparam logic [2:0] K_WR   = 3'd1;
  localparam logic [2:0] K_BAD  = 3'd2;  // write whose trailer lacks the end marker
  localparam logic [2:0] K_JUNK = 3'd3;  // word without a start marker
  localparam logic [2:0] K_RSP  = 3'd4;
  localparam int N_ENT   = 12;
  localparam int TIMEOUT = 3000;

  typedef struct packed {
    logic [2:0]         kind;
    logic [ID_W-1:0]    id;
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;
    logic [SIZE_W-1:0]  size;
    logic [BURST_W-1:0] burst;
    logic [LOCK_W-1:0]  lock;
    logic [CACHE_W-1:0] cache;
    logic [PROT_W-1:0]  prot;
    logic [STRB_W-1:0]  strb;
    logic [ID_W-1:0]    bid;
    logic [RESP_W-1:0]  bresp;
  } entry_t;

  // kind, id, addr, len, size, burst, lock, cache, prot, strb, bid, bresp
  entry_t tbl [N_ENT] = '{
    '{K_RD,   4'h3, 32'h1000_0040, 4'd7,  3'd3, 2'd1, 2'd0, 2'd2, 3'd1, 4'h0, 4'h0, 2'd0},
    '{K_WR,   4'h5, 32'h2000_0000, 4'd0,  3'd3, 2'd1, 2'd0, 2'd3, 3'd2, 4'hF, 4'h0, 2'd0},
    '{K_WR,   4'h6, 32'h2000_0100, 4'd1,  3'd2, 2'd1, 2'd1, 2'd0, 3'd0, 4'h3, 4'h0, 2'd0},
    '{K_RSP,  4'h0, 32'h0,         4'd0,  3'd0, 2'd0, 2'd0, 2'd0, 3'd0, 4'h0, 4'h9, 2'd2},
    '{K_BAD,  4'h7, 32'h3000_0000, 4'd4,  3'd3, 2'd2, 2'd0, 2'd1, 3'd4, 4'hC, 4'h0, 2'd0},
    '{K_JUNK, 4'h0, 32'h0,         4'd0,  3'd0, 2'd0, 2'd0, 2'd0, 3'd0, 4'h0, 4'h0, 2'd0},
    '{K_RD,   4'hA, 32'h4000_1000, 4'd15, 3'd3, 2'd1, 2'd2, 2'd3, 3'd7, 4'h0, 4'h0, 2'd0},
    '{K_BAD,  4'hB, 32'h3000_0800, 4'd3,  3'd3, 2'd1, 2'd0, 2'd2, 3'd1, 4'h6, 4'h0, 2'd0},
    '{K_WR,   4'hC, 32'h5000_0000, 4'd15, 3'd3, 2'd1, 2'd0, 2'd3, 3'd0, 4'hF, 4'h0, 2'd0},
    '{K_RSP,  4'h0, 32'h0,         4'd0,  3'd0, 2'd0, 2'd0, 2'd0, 3'd0, 4'h0, 4'hC, 2'd1},
    '{K_WR,   4'h1, 32'h6000_0020, 4'd6,  3'd3, 2'd0, 2'd0, 2'd1, 3'd2, 4'h5, 4'h0, 2'd0},
    '{K_RD,   4'h2, 32'h7000_0000, 4'd0,  3'd2, 2'd2, 2'd1, 2'd0, 3'd3, 4'h0, 4'h0, 2'd0}
  };

  logic clk = 1'b0;
  logic rst_n;
  logic fifo_empty = 1'b1;
  logic [FIFO_W-1:0] fifo_rdata = '0;
  logic read_enable, sop_err, rd_req, wr_req, w_valid, w_last, eop_err;
  logic wr_rsp_en, rsp_write;
  logic [ID_W-1:0] ar_id, aw_id, bid;
  logic [ADDR_W-1:0] ar_addr, aw_addr;
  logic [LEN_W-1:0] ar_len, aw_len;
  logic [SIZE_W-1:0] ar_size, aw_size;
  logic [BURST_W-1:0] ar_burst, aw_burst;
  logic [LOCK_W-1:0] ar_lock, aw_lock;
  logic [CACHE_W-1:0] ar_cache, aw_cache;
  logic [PROT_W-1:0] ar_prot, aw_prot;
  logic [STRB_W-1:0] w_strb;
  logic [BEAT_W-1:0] w_data;
  logic [RESP_W-1:0] bresp;
  logic [FIFO_W-1:0] rsp_data;

  logic [FIFO_W-1:0] word_q [$];  // words not yet popped by the DUT
  entry_t rd_q [$];
  entry_t wr_q [$];
  logic [68:0] w_q [$];           // strb, last, data per beat
  int sop_exp = 0;
  int sop_seen = 0;
  int eop_exp = 0;
  int eop_seen = 0;
  logic pop_seen = 1'b0;
  logic [31:0] gap_seed = 32'h5422;
  logic [31:0] data_seed = 32'h5422;

  axi_pkt_bridge i_axi_pkt_bridge (.*);

  always #50 clk = ~clk;

  function automatic logic [31:0] next_lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic rand64(output logic [63:0] r);
    data_seed = next_lcg(data_seed);
    r[63:32] = data_seed;
    data_seed = next_lcg(data_seed);
    r[31:0] = data_seed;
  endtask

  task automatic fail_now();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      fail_now();
    end
  endtask

  task automatic compare_request(input string p, input entry_t e,
                                 input logic [ID_W-1:0] id,
                                 input logic [ADDR_W-1:0] addr, input logic [LEN_W-1:0] len,
                                 input logic [SIZE_W-1:0] size,
                                 input logic [BURST_W-1:0] burst,
                                 input logic [LOCK_W-1:0] lock,
                                 input logic [CACHE_W-1:0] cache,
                                 input logic [PROT_W-1:0] prot);
    check_value({p, "_id"}, 128'(id), 128'(e.id));
    check_value({p, "_addr"}, 128'(addr), 128'(e.addr));
    check_value({p, "_len"}, 128'(len), 128'(e.len));
    check_value({p, "_size"}, 128'(size), 128'(e.size));
    check_value({p, "_burst"}, 128'(burst), 128'(e.burst));
    check_value({p, "_lock"}, 128'(lock), 128'(e.lock));
    check_value({p, "_cache"}, 128'(cache), 128'(e.cache));
    check_value({p, "_prot"}, 128'(prot), 128'(e.prot));
  endtask

  task automatic scan_outputs();
    entry_t e;
    logic [68:0] b;
    if (rd_req)
    begin
      if (rd_q.size() == 0)
      begin
        $display("rd_req pulsed with no read header pending");
        fail_now();
      end
      else
      begin
        e = rd_q.pop_front();
        compare_request("ar", e, ar_id, ar_addr, ar_len, ar_size, ar_burst, ar_lock,
                        ar_cache, ar_prot);
      end
    end
    if (wr_req)
    begin
      if (wr_q.size() == 0)
      begin
        $display("wr_req pulsed with no write header pending");
        fail_now();
      end
      else
      begin
        e = wr_q.pop_front();
        compare_request("aw", e, aw_id, aw_addr, aw_len, aw_size, aw_burst, aw_lock,
                        aw_cache, aw_prot);
        check_value("w_strb", 128'(w_strb), 128'(e.strb));
      end
    end
    if (w_valid)
    begin
      if (w_q.size() == 0)
      begin
        $display("w_valid pulsed with no write beat pending");
        fail_now();
      end
      else
      begin
        b = w_q.pop_front();
        check_value("w_data", 128'(w_data), 128'(b[63:0]));
        check_value("w_last", 128'(w_last), 128'(b[64]));
        check_value("w_strb", 128'(w_strb), 128'(b[68:65]));
      end
    end
  endtask

  // header word, then payload halves hi first, then the trailer half
  task automatic push_entry(input entry_t e);
    logic [63:0] halves [$];
    logic [63:0] d;
    logic [63:0] r;
    logic [15:0] kind_code;
    int n;
    int i;
    rand64(r);
    kind_code = (e.kind == K_RD) ? 16'h0113 : 16'h0B00;
    if (e.kind == K_JUNK)
    begin
      rand64(d);
      word_q.push_back({8'h3C, d[55:0], r});
      sop_exp = sop_exp + 1;
    end
    else
    begin
      word_q.push_back({8'hAA, e.id, e.addr, e.len, e.size, e.burst, e.lock, e.cache,
                        e.prot, e.strb, kind_code, r[47:0]});
      if (e.kind == K_RD)
      begin
        rd_q.push_back(e);
      end
      else
      begin
        wr_q.push_back(e);
        n = int'(e.len) + 1;  // whole beats only
        for (i = 0; i < n; i++)
        begin
          rand64(d);
          halves.push_back(d);
          w_q.push_back({e.strb, (i == n - 1), d});
        end
        rand64(d);
        d[63:56] = (e.kind == K_BAD) ? 8'hC5 : 8'h53;
        halves.push_back(d);
        if (e.kind == K_BAD)
        begin
          eop_exp = eop_exp + 1;
        end
        if (halves.size() % 2 == 1)
        begin
          rand64(d);  // lo half after a hi trailer is discarded
          halves.push_back(d);
        end
        for (i = 0; i < halves.size(); i += 2)
        begin
          word_q.push_back({halves[i], halves[i + 1]});
        end
      end
    end
  endtask

  task automatic send_response(input entry_t e);
    @(posedge clk);
    wr_rsp_en <= 1'b1;
    bid <= e.bid;
    bresp <= e.bresp;
    @(posedge clk);
    wr_rsp_en <= 1'b0;
    @(negedge clk);
    check_value("rsp_write", 128'(rsp_write), 128'(1'b1));
    check_value("rsp_data", rsp_data, {104'h0, 8'hAA, e.bid, 2'b00, e.bresp, 8'h53});
  endtask

  task automatic wait_drained();
    int wait_cycles;
    wait_cycles = 0;
    while (word_q.size() != 0 || rd_q.size() != 0 || wr_q.size() != 0 || w_q.size() != 0 ||
           sop_seen != sop_exp || eop_seen != eop_exp)
    begin
      @(negedge clk);
      wait_cycles++;
      if (wait_cycles > TIMEOUT)
      begin
        if (word_q.size() != 0)
          $display("timeout: the DUT stopped popping FIFO words");
        else if (rd_q.size() != 0)
          $display("timeout: rd_req never came for a read header");
        else if (wr_q.size() != 0)
          $display("timeout: wr_req never came for a write header");
        else if (w_q.size() != 0)
          $display("timeout: write beats never came on w_valid");
        else
          $display("timeout: an expected sop_err or eop_err pulse never came");
        fail_now();
      end
    end
  endtask

  // FIFO model with empty gaps only while a new head word is due
  always @(negedge clk) pop_seen <= read_enable;

  always @(posedge clk)
  begin
    if (pop_seen)
    begin
      word_q.delete(0);
    end
    if (pop_seen || fifo_empty)
    begin
      gap_seed = next_lcg(gap_seed);
      if (word_q.size() > 0 && gap_seed[17:16] != 2'b00)
      begin
        fifo_empty <= 1'b0;
        fifo_rdata <= word_q[0];
      end
      else
      begin
        fifo_empty <= 1'b1;
      end
    end
  end

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      scan_outputs();
      if (sop_err)
        sop_seen = sop_seen + 1;
      if (eop_err)
        eop_seen = eop_seen + 1;
      if (sop_seen > sop_exp)
      begin
        $display("sop_err pulsed more often than junk words were sent");
        fail_now();
      end
      if (eop_seen > eop_exp)
      begin
        $display("eop_err pulsed more often than bad trailers were sent");
        fail_now();
      end
      if (i_axi_pkt_bridge.i_bridge_assert.fail_cnt != 0)
      begin
        $display("a protocol assertion on the bridge ports failed");
        fail_now();
      end
    end
  end

  initial
  begin
    int i;
    rst_n = 1'b0;
    wr_rsp_en = 1'b0;
    bid = '0;
    bresp = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (i = 0; i < N_ENT; i++)
    begin
      @(negedge clk);
      if (tbl[i].kind == K_RSP)
        send_response(tbl[i]);
      else
        push_entry(tbl[i]);  // packets overlap in the pipeline
    end
    wait_drained();
    repeat (10) @(negedge clk);  // room for stray pulses
    check_value("sop_err count", 128'(sop_seen), 128'(sop_exp));
    check_value("eop_err count", 128'(eop_seen), 128'(eop_exp));
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
design/bridge_pkg.sv
design/pkt_if.sv
design/pkt_parser.sv
design/req_gen.sv
design/rsp_packer.sv
design/axi_pkt_bridge.sv
verif/axi_pkt_bridge_assert.sv
verif/axi_pkt_bridge_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the bridge testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert --top-module axi_pkt_bridge_tb \
  -f filelist.f -o bridge_sim > "$build_log" 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "build failed with status $build_status, see $build_log"
  exit 1
fi

# let assertion errors reach the testbench instead of stopping at the first one
./obj_dir/bridge_sim +verilator+error+limit+100 > "$sim_log" 2>&1
run_status=$?
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status, see $sim_log"
  exit 1
fi

if grep -qx "TEST PASSED" "$sim_log"; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see $sim_log"
exit 1
